// File: src/tcb_pkg.sv
// TCB memory subordinate package: bus widths, transfer structs and operation codes
`default_nettype none

package tcb_pkg;

  //////////////////////////////
  // bus widths
  //////////////////////////////

  // address width
  localparam int unsigned tcb_abw = 32;
  // data width
  localparam int unsigned tcb_dbw = 32;
  // byte enables per word
  localparam int unsigned tcb_bew = 4;
  // width of the internal word index, caps MEM_AW at 16
  localparam int unsigned mem_idw = 16;

  //////////////////////////////
  // bus payload
  //////////////////////////////

  // request as seen on the bus, sampled on a transfer
  typedef struct packed {
    logic               wen;  // write enable
    logic [tcb_abw-1:0] adr;  // byte address
    logic [tcb_bew-1:0] ben;  // byte enables
    logic [tcb_dbw-1:0] wdt;  // write data
  } tcb_req_t;

  // response, DLY cycles after the transfer
  typedef struct packed {
    logic [tcb_dbw-1:0] rdt;  // read data
    logic               err;  // error
  } tcb_rsp_t;

  //////////////////////////////
  // internal command
  //////////////////////////////

  // classified operation
  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1,
    op_fault = 2'd2   // address outside memory or misaligned
  } tcb_op_t;

  // command from the input side to the memory
  typedef struct packed {
    tcb_op_t            op;
    logic [mem_idw-1:0] idx;  // word index
    logic [tcb_bew-1:0] ben;
    logic [tcb_dbw-1:0] wdt;
  } mem_cmd_t;

endpackage: tcb_pkg

`default_nettype wire

// File: src/tcb_req_dec.sv
// TCB request decoder: accepts transfers, checks the address range, registers a command
`timescale 1ns/1ps
`default_nettype none

module tcb_req_dec #(
  // memory word address width
  parameter int unsigned MEM_AW = 8
)(
  // system signals
  input  logic              tcb,
  input  logic              rst_n,
  // bus request
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  // command towards memory
  output logic              cmd_vld,
  output tcb_pkg::mem_cmd_t cmd
);

  import tcb_pkg::*;

  //////////////////////////////
  // local parameters
  //////////////////////////////

  // byte offset bits inside a word
  localparam int unsigned off_w = $clog2(tcb_bew);
  // address bits that must be zero for an in-range access
  localparam logic [tcb_abw-1:0] rng_msk = {tcb_abw{1'b1}} << (MEM_AW + off_w);

  //////////////////////////////
  // local signals
  //////////////////////////////

  // transfer strobe
  logic               trn;
  // address checks
  logic               adr_rng;
  logic               adr_mis;
  // classified request
  tcb_op_t            op_nxt;
  logic [mem_idw-1:0] idx_nxt;

  //////////////////////////////
  // handshake
  //////////////////////////////

  // ready after reset, never stalls otherwise
  // independent of vld, no loop through the manager
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  // transfer when both sides agree
  assign trn = vld & rdy;

  //////////////////////////////
  // classification
  //////////////////////////////

  // bits above the memory window
  assign adr_rng = |(req.adr & rng_msk);
  // not word aligned
  assign adr_mis = |req.adr[off_w-1:0];

  always_comb begin
    if (adr_rng || adr_mis) begin
      op_nxt = op_fault;
    end else if (req.wen) begin
      op_nxt = op_write;
    end else begin
      op_nxt = op_read;
    end
  end

  // word index, zero extended to the command field
  always_comb begin
    idx_nxt             = '0;
    idx_nxt[MEM_AW-1:0] = req.adr[off_w +: MEM_AW];
  end

  //////////////////////////////
  // command register
  //////////////////////////////

  // valid follows each transfer, bubble on idle
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      cmd_vld <= 1'b0;
    end else begin
      cmd_vld <= trn;
    end
  end

  // payload only loads on a transfer
  // ben/wdt of a fault are carried along, memory ignores them
  always_ff @(posedge tcb) begin
    if (trn) begin
      cmd.op  <= op_nxt;
      cmd.idx <= idx_nxt;
      cmd.ben <= req.ben;
      cmd.wdt <= req.wdt;
    end
  end

endmodule: tcb_req_dec

`default_nettype wire

// File: src/tcb_mem.sv
// TCB memory core: byte-enabled synchronous word memory executing decoded commands
`timescale 1ns/1ps
`default_nettype none

module tcb_mem #(
  // memory word address width
  parameter int unsigned MEM_AW = 8
)(
  // system signals
  input  logic              tcb,
  input  logic              rst_n,
  // command from the decoder
  input  logic              cmd_vld,
  input  tcb_pkg::mem_cmd_t cmd,
  // response towards the pipeline
  output logic              mem_vld,
  output tcb_pkg::tcb_rsp_t mem_rsp
);

  import tcb_pkg::*;

  //////////////////////////////
  // local parameters
  //////////////////////////////

  // byte width
  localparam int unsigned byt_w = tcb_dbw / tcb_bew;
  // number of words
  localparam int unsigned mem_sz = 2**MEM_AW;

  //////////////////////////////
  // local signals
  //////////////////////////////

  // storage array
  logic [tcb_dbw-1:0] mem [0:mem_sz-1];

  // word address inside the array
  logic [MEM_AW-1:0]  adr;

  // operation strobes
  logic               wr_en;
  logic               rd_en;
  logic               flt;

  //////////////////////////////
  // decode
  //////////////////////////////

  // upper index bits are zero for in-range commands
  assign adr = cmd.idx[MEM_AW-1:0];

  assign wr_en = cmd_vld && (cmd.op == op_write);
  assign flt   = cmd.op == op_fault;
  assign rd_en = cmd_vld;

  //////////////////////////////
  // write port
  //////////////////////////////

  // only enabled byte lanes change
  always_ff @(posedge tcb) begin
    if (wr_en) begin
      for (int unsigned b = 0; b < tcb_bew; b++) begin
        if (cmd.ben[b]) begin
          mem[adr][b*byt_w +: byt_w] <= cmd.wdt[b*byt_w +: byt_w];
        end
      end
    end
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // read before write, so a write returns the old word
  // fault gives zero data with error set
  always_ff @(posedge tcb) begin
    if (rd_en) begin
      if (flt) begin
        mem_rsp.rdt <= '0;
        mem_rsp.err <= 1'b1;
      end else begin
        mem_rsp.rdt <= mem[adr];
        mem_rsp.err <= 1'b0;
      end
    end
  end

  // response marker, one cycle behind the command
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      mem_vld <= 1'b0;
    end else begin
      mem_vld <= cmd_vld;
    end
  end

endmodule: tcb_mem

`default_nettype wire

// File: src/tcb_rsp_pipe.sv
// TCB response delay line: brings the memory response out DLY cycles after the transfer
`timescale 1ns/1ps
`default_nettype none

module tcb_rsp_pipe #(
  // total response delay in cycles, at least 1
  parameter int unsigned DLY = 2
)(
  // system signals
  input  logic              tcb,
  input  logic              rst_n,
  // response from memory
  input  logic              mem_vld,
  input  tcb_pkg::tcb_rsp_t mem_rsp,
  // response on the bus
  output logic              rsp_vld,
  output tcb_pkg::tcb_rsp_t rsp
);

  import tcb_pkg::*;

  generate
  if (DLY == 1) begin: g_thru

    //////////////////////////////
    // no extra delay
    //////////////////////////////

    // memory read already spans the one cycle
    assign rsp_vld = mem_vld;
    assign rsp     = mem_rsp;

  end else begin: g_pipe

    //////////////////////////////
    // shift register
    //////////////////////////////

    // decoder and memory give the first cycle of the stage count
    localparam int unsigned stg = DLY - 1;

    // valid bits per stage
    logic     [stg-1:0] vld_sr;
    // response payload per stage
    tcb_rsp_t           rsp_sr [stg];

    // valid shifts in at stage 0
    always_ff @(posedge tcb) begin
      if (!rst_n) begin
        vld_sr <= '0;
      end else begin
        vld_sr[0] <= mem_vld;
        for (int unsigned i = 1; i < stg; i++) begin
          vld_sr[i] <= vld_sr[i-1];
        end
      end
    end

    // data follows the valid bits
    // bubbles shift stale data along with a low valid
    always_ff @(posedge tcb) begin
      rsp_sr[0] <= mem_rsp;
      for (int unsigned i = 1; i < stg; i++) begin
        rsp_sr[i] <= rsp_sr[i-1];
      end
    end

    // last stage drives the bus
    assign rsp_vld = vld_sr[stg-1];
    assign rsp     = rsp_sr[stg-1];

  end
  endgenerate

endmodule: tcb_rsp_pipe

`default_nettype wire

// File: src/tcb_mem_sub.sv
// TCB memory subordinate top: decoder, memory and response delay line
`timescale 1ns/1ps
`default_nettype none

module tcb_mem_sub #(
  // response delay in cycles, at least 1
  parameter int unsigned DLY    = 2,
  // memory word address width, 256 words by default
  parameter int unsigned MEM_AW = 8
)(
  // system signals
  input  logic              tcb,
  input  logic              rst_n,
  // request handshake
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  // response
  output logic              rsp_vld,
  output tcb_pkg::tcb_rsp_t rsp
);

  import tcb_pkg::*;

  //////////////////////////////
  // internal links
  //////////////////////////////

  // decoder to memory
  logic     cmd_vld;
  mem_cmd_t cmd;

  // memory to delay line
  logic     mem_vld;
  tcb_rsp_t mem_rsp;

  //////////////////////////////
  // instances
  //////////////////////////////

  // input side, address check and command register
  tcb_req_dec #(
    .MEM_AW  (MEM_AW)
  ) req_dec (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .cmd_vld (cmd_vld),
    .cmd     (cmd)
  );

  // storage
  tcb_mem #(
    .MEM_AW  (MEM_AW)
  ) mem (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .cmd_vld (cmd_vld),
    .cmd     (cmd),
    .mem_vld (mem_vld),
    .mem_rsp (mem_rsp)
  );

  // output side, remaining delay
  tcb_rsp_pipe #(
    .DLY     (DLY)
  ) rsp_pipe (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .mem_vld (mem_vld),
    .mem_rsp (mem_rsp),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

endmodule: tcb_mem_sub

`default_nettype wire

// File: tests/tcb_vip_man.sv
// TCB manager model: drives vld/req transfers and follows each fixed-delay response
`timescale 1ns/1ps
`default_nettype none

module tcb_vip_man #(
  // response delay of the subordinate
  parameter int unsigned DLY = 2,
  // cycles to wait for rdy before dropping a transfer
  parameter int unsigned TMO = 64
)(
  // system signals
  input  logic              tcb,
  input  logic              rst_n,
  // request handshake
  output logic              vld,
  output tcb_pkg::tcb_req_t req,
  input  logic              rdy,
  // response marker
  input  logic              rsp_vld
);

  import tcb_pkg::*;

  //////////////////////////////
  // model state
  //////////////////////////////

  // transfers dropped for lack of rdy
  int unsigned tmo_cnt  = 0;
  // responses not seen when due
  int unsigned miss_cnt = 0;
  // responses seen on time
  int unsigned rsp_cnt  = 0;
  // edges elapsed per transfer in flight
  int unsigned age_q [$];

  // bus idle from time zero
  initial begin
    vld = 1'b0;
    req = '0;
  end

  //////////////////////////////
  // transfer driver
  //////////////////////////////

  // caller sits on a rising edge
  // returns on the transfer edge with vld still high, for back-to-back use
  task automatic drive(input tcb_req_t r);
    int unsigned n;
    n = 0;
    vld <= 1'b1;
    req <= r;
    @(posedge tcb);
    while (rdy !== 1'b1 && n < TMO) begin
      @(posedge tcb);
      n++;
    end
    if (rdy !== 1'b1) begin
      tmo_cnt++;
      $display("%0t: subordinate kept rdy low for %0d cycles, transfer dropped", $time, TMO);
      vld <= 1'b0;
    end
  endtask

  // drop vld for n cycles
  // n of zero only ends the burst
  task automatic idle(input int unsigned n);
    vld <= 1'b0;
    repeat (n) @(posedge tcb);
  endtask

  //////////////////////////////
  // access tasks
  //////////////////////////////

  task automatic write_req(input logic [31:0] adr, input logic [3:0] ben,
                           input logic [31:0] wdt);
    tcb_req_t r;
    r.wen = 1'b1;
    r.adr = adr;
    r.ben = ben;
    r.wdt = wdt;
    drive(r);
  endtask

  // full word read with write data unused
  task automatic read_req(input logic [31:0] adr);
    tcb_req_t r;
    r.wen = 1'b0;
    r.adr = adr;
    r.ben = 4'hf;
    r.wdt = '0;
    drive(r);
  endtask

  //////////////////////////////
  // response listener
  //////////////////////////////

  // each transfer ages one step per edge
  // after DLY edges the response stands on the bus and is taken at the next one
  always @(posedge tcb) begin
    if (rst_n !== 1'b1) begin
      age_q.delete();
    end else begin
      if (age_q.size() > 0 && age_q[0] == DLY) begin
        void'(age_q.pop_front());
        if (rsp_vld === 1'b1) begin
          rsp_cnt++;
        end else begin
          miss_cnt++;
          $display("%0t: no response %0d cycles after the transfer", $time, DLY);
        end
      end
      foreach (age_q[i]) begin
        age_q[i]++;
      end
      if (vld && rdy === 1'b1) begin
        age_q.push_back(0);
      end
    end
  end

endmodule: tcb_vip_man

`default_nettype wire

// File: tests/tcb_mem_sub_tb.sv
// TCB memory subordinate testbench: scoreboard memory, random traffic and bus assertions
`timescale 1ns/1ps
`default_nettype none

module tcb_mem_sub_tb;

  import tcb_pkg::*;

  //////////////////////////////
  // setup
  //////////////////////////////

  localparam int unsigned DLY     = 2;
  localparam int unsigned MEM_AW  = 8;
  localparam int unsigned MEM_WDS = 2**MEM_AW;
  localparam int unsigned N_RND   = 400;
  localparam int unsigned LIMIT   = 20000;

  // msk marks the known data bits of the expected response
  typedef struct packed {
    logic [31:0] rdt;
    logic [31:0] msk;
    logic        err;
  } exp_t;

  logic        tcb = 1'b0;
  logic        rst_n;
  logic        vld;
  tcb_req_t    req;
  logic        rdy;
  logic        rsp_vld;
  tcb_rsp_t    rsp;
  logic        trn;

  // shadow memory and its known bits
  logic [31:0] shd   [MEM_WDS];
  logic [31:0] known [MEM_WDS];
  exp_t        exp_q [$];
  exp_t        exp_head;
  logic        exp_vld = 1'b0;
  int unsigned cyc     = 0;
  int unsigned err_cnt = 0;
  int unsigned tmo_cnt = 0;
  logic        done    = 1'b0;
  logic [31:0] rnd_st  = 32'h3fcc_370a;

  always #4 tcb = ~tcb;

  assign trn = vld & rdy;

  tcb_mem_sub #(
    .DLY     (DLY),
    .MEM_AW  (MEM_AW)
  ) UUT (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  tcb_vip_man #(
    .DLY     (DLY)
  ) man (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .rsp_vld (rsp_vld)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rnd_st = xorshift32(rnd_st);
    return rnd_st;
  endfunction

  // every byte of the initial contents tied to the word index
  function automatic logic [31:0] fill_word(input int unsigned i);
    logic [7:0] b;
    b = i[7:0];
    return {~b, b ^ 8'h5a, b, {b[3:0], b[7:4]}};
  endfunction

  // fault when beyond the window or misaligned, otherwise the old word
  function automatic exp_t predict(input tcb_req_t r);
    exp_t        e;
    logic [31:0] w;
    e = '0;
    if (r.adr >= MEM_WDS * 4 || r.adr[1:0] != 2'b00) begin
      e.err = 1'b1;
      e.msk = '1;
    end else begin
      w     = r.adr >> 2;
      e.rdt = shd[w];
      e.msk = known[w];
      if (r.wen) begin
        for (int b = 0; b < 4; b++) begin
          if (r.ben[b]) begin
            shd[w][b*8 +: 8]   = r.wdt[b*8 +: 8];
            known[w][b*8 +: 8] = 8'hff;
          end
        end
      end
    end
    return e;
  endfunction

  //////////////////////////////
  // scoreboard
  //////////////////////////////

  // pop on response, push on transfer, head feeds the assertions
  always @(posedge tcb) begin
    cyc <= cyc + 1;
    if (rsp_vld === 1'b1 && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
    if (trn === 1'b1) begin
      exp_q.push_back(predict(req));
    end
    exp_vld = exp_q.size() > 0;
    if (exp_vld) begin
      exp_head = exp_q[0];
    end
  end

  //////////////////////////////
  // assertions
  //////////////////////////////

  // quiet while in reset
  a_rst: assert property (@(posedge tcb) !$past(rst_n) |-> !rdy && !rsp_vld)
    else begin
      err_cnt = err_cnt + 1;
      $display("Mismatch at %0t: rdy %b rsp_vld %b during reset", $time,
               $sampled(rdy), $sampled(rsp_vld));
    end

  // ready one cycle after release and from then on
  a_rdy: assert property (@(posedge tcb) $past(rst_n) |-> rdy)
    else begin
      err_cnt = err_cnt + 1;
      $display("Mismatch at %0t: rdy low after reset release", $time);
    end

  // response exactly DLY cycles after its transfer, bubbles stay empty
  a_dly: assert property (@(posedge tcb) cyc > DLY + 1 |-> rsp_vld == $past(trn, DLY + 1))
    else begin
      err_cnt = err_cnt + 1;
      $display("Mismatch at %0t: rsp_vld %b does not follow the transfer %0d cycles earlier",
               $time, $sampled(rsp_vld), DLY);
    end

  a_pend: assert property (@(posedge tcb) rsp_vld |-> exp_vld)
    else begin
      err_cnt = err_cnt + 1;
      $display("%0t: response arrived with no transfer pending", $time);
    end

  a_err: assert property (@(posedge tcb) rsp_vld && exp_vld |-> rsp.err == exp_head.err)
    else begin
      err_cnt = err_cnt + 1;
      $display("Mismatch at %0t: err %b expected %b", $time,
               $sampled(rsp.err), $sampled(exp_head.err));
    end

  // unknown shadow bits are masked out
  a_rdt: assert property (@(posedge tcb)
    rsp_vld && exp_vld |-> ((rsp.rdt ^ exp_head.rdt) & exp_head.msk) == '0)
    else begin
      err_cnt = err_cnt + 1;
      $display("Mismatch at %0t: rdt %h expected %h mask %h", $time, $sampled(rsp.rdt),
               $sampled(exp_head.rdt), $sampled(exp_head.msk));
    end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    int unsigned n;
    for (int i = 0; i < MEM_WDS; i++) begin
      shd[i]   = '0;
      known[i] = '0;
    end
    rst_n = 1'b0;
    repeat (3) @(posedge tcb);
    rst_n <= 1'b1;
    @(posedge tcb);
    // fill the whole memory back to back
    for (int unsigned i = 0; i < MEM_WDS; i++) begin
      man.write_req(i * 4, 4'hf, fill_word(i));
    end
    man.idle(2);
    // write returns old word, read returns new one
    man.write_req(32'h40, 4'hf, 32'hdead_beef);
    man.read_req(32'h40);
    man.write_req(32'h44, 4'b0101, 32'h1122_3344);
    man.read_req(32'h44);
    man.idle(1);
    // first fault aliases word 0 if the range check is missing
    man.write_req(32'h400, 4'hf, 32'h0bad_0bad);
    man.write_req(32'h41, 4'hf, 32'h0bad_0bad);
    man.read_req(32'h8000_0000);
    man.read_req(32'h0);
    man.read_req(32'h40);
    man.idle(3);
    // random mix with occasional faults and idle gaps
    for (int i = 0; i < N_RND; i++) begin
      r = next_rand();
      a = {22'd0, r[7:0], 2'b00};
      if (r[31:28] == 4'h0) begin
        a[1:0] = r[9:8] | 2'b01;
      end else if (r[31:28] == 4'h1) begin
        a = a | (32'h400 << r[14:11]);
      end
      if (r[16]) begin
        man.write_req(a, r[20:17], next_rand());
      end else begin
        man.read_req(a);
      end
      man.idle(r[23:21] < 3'd5 ? 0 : r[25:24]);
    end
    man.idle(0);
    // drain outstanding responses
    n = 0;
    while (exp_q.size() > 0 && n < 64) begin
      @(posedge tcb);
      n++;
    end
    if (exp_q.size() > 0) begin
      tmo_cnt++;
      $display("%0t: %0d responses still pending after drain", $time, exp_q.size());
    end
    @(posedge tcb);
    done = 1'b1;
    $display("checks: %0d responses, %0d mismatches, %0d missing responses, %0d timeouts",
             man.rsp_cnt, err_cnt, man.miss_cnt, tmo_cnt + man.tmo_cnt);
    if (err_cnt == 0 && man.miss_cnt == 0 && tmo_cnt == 0 && man.tmo_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // hard limit on the whole run
  initial begin
    int unsigned n;
    n = 0;
    while (!done && n < LIMIT) begin
      @(posedge tcb);
      n++;
    end
    if (!done) begin
      $display("%0t: run did not finish within %0d cycles", $time, LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

endmodule: tcb_mem_sub_tb

`default_nettype wire

// File: sim.f
src/tcb_pkg.sv
src/tcb_req_dec.sv
src/tcb_mem.sv
src/tcb_rsp_pipe.sv
src/tcb_mem_sub.sv
tests/tcb_vip_man.sv
tests/tcb_mem_sub_tb.sv
